/* include/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// idle cycles spent in NOP after reset and per NOP opcode
`define CPU_NOP_DURATION 6

// special registers mapped inside the core
`define CPU_SFR_ACC 8'hE0
`define CPU_SFR_B   8'hF0
`define CPU_SFR_PSW 8'hD0

`endif

/* hdl/cpu_isa_pkg.sv */
`include "cpu_config.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;

    typedef logic [3:0] phase_t;  // phases left in the current instruction

    typedef enum logic [7:0] {
        OP_NOP       = 8'h00,
        OP_MOV_A_IMM = 8'h74,
        OP_MOV_A_DIR = 8'hE5,
        OP_MOV_DIR_A = 8'hF5,
        OP_ADD_A_IMM = 8'h24,
        OP_ADD_A_DIR = 8'h25,
        OP_ANL_A_IMM = 8'h54,
        OP_ORL_A_IMM = 8'h44,
        OP_XRL_A_IMM = 8'h64
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,  // result is operand b
        ALU_ADD  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_ACC      = 2'd0,
        SRC_ROM_DATA = 2'd1,
        SRC_RAM_DATA = 2'd2,
        SRC_NONE     = 2'd3
    } src_e;

endpackage

/* hdl/cpu_ctrl_pkg.sv */
`include "cpu_config.svh"

package cpu_ctrl_pkg;

    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // one-hot
    typedef enum logic [6:0] {
        ST_NOP        = 7'b000_0001,
        ST_GET_INS    = 7'b000_0010,
        ST_INS_DECODE = 7'b000_0100,
        ST_RAM_READ   = 7'b000_1000,
        ST_ROM_READ   = 7'b001_0000,
        ST_PROCESS    = 7'b010_0000,
        ST_RAM_WRITE  = 7'b100_0000
    } state_e;

    typedef enum logic [2:0] {
        NXT_NOP       = 3'b000,
        NXT_RAM_READ  = 3'b001,
        NXT_ROM_READ  = 3'b010,
        NXT_PROCESS   = 3'b011,
        NXT_RAM_WRITE = 3'b100,
        NXT_GET_INS   = 3'b101
    } next_e;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
    input  cpu_isa_pkg::alu_op_e op,
    input  cpu_isa_pkg::byte_t   a,
    input  cpu_isa_pkg::byte_t   b,
    input  cpu_isa_pkg::byte_t   psw_in,
    output cpu_isa_pkg::byte_t   result,
    output cpu_isa_pkg::byte_t   flags
);

    logic [8:0] sum;
    logic [4:0] low_sum;  // nibble add for aux carry

    assign sum     = {1'b0, a} + {1'b0, b};
    assign low_sum = {1'b0, a[3:0]} + {1'b0, b[3:0]};

    always_comb begin
        result = b;
        flags  = psw_in;
        case (op)
            cpu_isa_pkg::ALU_ADD: begin
                result   = sum[7:0];
                flags[7] = sum[8];  // CY
                flags[6] = low_sum[4];  // AC
                flags[2] = (a[7] == b[7]) && (sum[7] != a[7]);  // OV
            end
            cpu_isa_pkg::ALU_AND: result = a & b;
            cpu_isa_pkg::ALU_OR:  result = a | b;
            cpu_isa_pkg::ALU_XOR: result = a ^ b;
            default: ;
        endcase
    end

endmodule

/* hdl/ins_decoder.sv */
`timescale 1ns/1ns

module ins_decoder (
    input  cpu_isa_pkg::byte_t   opcode,
    input  cpu_isa_pkg::phase_t  phase,
    output cpu_ctrl_pkg::next_e  next_state,
    output cpu_isa_pkg::phase_t  phase_init,
    output cpu_isa_pkg::alu_op_e alu_op,
    output cpu_isa_pkg::src_e    a_src,
    output cpu_isa_pkg::src_e    b_src
);

    cpu_ctrl_pkg::next_e steps [3];  // phase list in execution order
    cpu_isa_pkg::phase_t left;
    cpu_isa_pkg::phase_t idx;

    always_comb begin
        steps      = '{default: cpu_ctrl_pkg::NXT_GET_INS};
        steps[0]   = cpu_ctrl_pkg::NXT_NOP;  // unknown opcodes idle
        phase_init = cpu_isa_pkg::phase_t'(1);
        alu_op     = cpu_isa_pkg::ALU_PASS;
        a_src      = cpu_isa_pkg::SRC_ACC;
        b_src      = cpu_isa_pkg::SRC_NONE;
        case (opcode)
            cpu_isa_pkg::OP_MOV_A_IMM,
            cpu_isa_pkg::OP_ADD_A_IMM,
            cpu_isa_pkg::OP_ANL_A_IMM,
            cpu_isa_pkg::OP_ORL_A_IMM,
            cpu_isa_pkg::OP_XRL_A_IMM: begin
                steps[0]   = cpu_ctrl_pkg::NXT_ROM_READ;
                steps[1]   = cpu_ctrl_pkg::NXT_PROCESS;
                phase_init = cpu_isa_pkg::phase_t'(2);
                b_src      = cpu_isa_pkg::SRC_ROM_DATA;
            end
            cpu_isa_pkg::OP_MOV_A_DIR,
            cpu_isa_pkg::OP_ADD_A_DIR: begin
                steps[0]   = cpu_ctrl_pkg::NXT_ROM_READ;  // direct address byte
                steps[1]   = cpu_ctrl_pkg::NXT_RAM_READ;
                steps[2]   = cpu_ctrl_pkg::NXT_PROCESS;
                phase_init = cpu_isa_pkg::phase_t'(3);
                b_src      = cpu_isa_pkg::SRC_RAM_DATA;
            end
            cpu_isa_pkg::OP_MOV_DIR_A: begin
                steps[0]   = cpu_ctrl_pkg::NXT_ROM_READ;
                steps[1]   = cpu_ctrl_pkg::NXT_RAM_WRITE;
                phase_init = cpu_isa_pkg::phase_t'(2);
            end
            default: ;
        endcase
        case (opcode)
            cpu_isa_pkg::OP_ADD_A_IMM, cpu_isa_pkg::OP_ADD_A_DIR: alu_op = cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::OP_ANL_A_IMM: alu_op = cpu_isa_pkg::ALU_AND;
            cpu_isa_pkg::OP_ORL_A_IMM: alu_op = cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::OP_XRL_A_IMM: alu_op = cpu_isa_pkg::ALU_XOR;
            default: ;
        endcase
    end

    // phase 0 means the sequencer has not loaded the count yet
    assign left = (phase == '0) ? phase_init : phase;
    assign idx  = phase_init - left;

    assign next_state = (left > phase_init) ? cpu_ctrl_pkg::NXT_GET_INS : steps[idx[1:0]];

endmodule

/* hdl/cpu_sequencer.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_ctrl_pkg::next_e  next_state,
    input  cpu_isa_pkg::phase_t  phase_init,
    input  cpu_ctrl_pkg::addr_t  pc,
    input  cpu_isa_pkg::byte_t   direct_addr,
    output cpu_ctrl_pkg::addr_t  addr_bus,
    output logic                 read_en,
    output logic                 write_en,
    output logic                 memory_select,
    output logic                 load_ins,
    output logic                 load_rom,
    output logic                 load_ram,
    output logic                 exec,
    output logic                 ram_write,
    output cpu_isa_pkg::phase_t  phase,
    output cpu_ctrl_pkg::state_e state
);

    localparam int NOP_W = $clog2(`CPU_NOP_DURATION + 1);
    localparam logic [NOP_W-1:0] NOP_LOAD = NOP_W'(`CPU_NOP_DURATION);

    logic [NOP_W-1:0] nop_cnt;
    logic             done;  // strobe cycle of a memory state

    // last phase goes back to fetch
    function automatic cpu_ctrl_pkg::state_e after_phase(input cpu_isa_pkg::phase_t ph);
        if (ph == cpu_isa_pkg::phase_t'(1))
            return cpu_ctrl_pkg::ST_GET_INS;
        return cpu_ctrl_pkg::ST_INS_DECODE;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= cpu_ctrl_pkg::ST_NOP;
            nop_cnt       <= NOP_LOAD;
            phase         <= '0;
            done          <= 1'b0;
            read_en       <= 1'b0;
            write_en      <= 1'b0;
            memory_select <= 1'b1;
            addr_bus      <= '0;
        end else begin
            read_en  <= 1'b0;
            write_en <= 1'b0;
            done     <= 1'b0;
            case (state)
                cpu_ctrl_pkg::ST_NOP: begin
                    if (nop_cnt == '0) begin
                        state   <= cpu_ctrl_pkg::ST_GET_INS;
                        nop_cnt <= NOP_LOAD;
                    end else begin
                        nop_cnt <= nop_cnt - 1'b1;
                    end
                end
                cpu_ctrl_pkg::ST_GET_INS: begin
                    phase         <= '0;
                    memory_select <= 1'b0;
                    if (done) begin
                        state <= cpu_ctrl_pkg::ST_INS_DECODE;
                    end else begin
                        addr_bus <= pc;
                        read_en  <= 1'b1;
                        done     <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::ST_INS_DECODE: begin
                    if (phase == '0)
                        phase <= phase_init;  // first decode of this opcode
                    case (next_state)
                        cpu_ctrl_pkg::NXT_RAM_READ:  state <= cpu_ctrl_pkg::ST_RAM_READ;
                        cpu_ctrl_pkg::NXT_ROM_READ:  state <= cpu_ctrl_pkg::ST_ROM_READ;
                        cpu_ctrl_pkg::NXT_PROCESS:   state <= cpu_ctrl_pkg::ST_PROCESS;
                        cpu_ctrl_pkg::NXT_RAM_WRITE: state <= cpu_ctrl_pkg::ST_RAM_WRITE;
                        cpu_ctrl_pkg::NXT_GET_INS:   state <= cpu_ctrl_pkg::ST_GET_INS;
                        default:                     state <= cpu_ctrl_pkg::ST_NOP;
                    endcase
                end
                cpu_ctrl_pkg::ST_ROM_READ: begin
                    memory_select <= 1'b0;
                    if (done) begin
                        state <= after_phase(phase);
                        phase <= phase - 1'b1;
                    end else begin
                        addr_bus <= pc;  // operand follows opcode
                        read_en  <= 1'b1;
                        done     <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::ST_RAM_READ: begin
                    memory_select <= 1'b1;
                    if (done) begin
                        state <= after_phase(phase);
                        phase <= phase - 1'b1;
                    end else begin
                        addr_bus <= cpu_ctrl_pkg::addr_t'(direct_addr);
                        read_en  <= 1'b1;
                        done     <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::ST_RAM_WRITE: begin
                    memory_select <= 1'b1;
                    if (done) begin
                        state <= after_phase(phase);
                        phase <= phase - 1'b1;
                    end else begin
                        addr_bus <= cpu_ctrl_pkg::addr_t'(direct_addr);
                        write_en <= 1'b1;
                        done     <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::ST_PROCESS: begin
                    state <= after_phase(phase);
                    phase <= phase - 1'b1;
                end
                default: state <= cpu_ctrl_pkg::ST_NOP;  // lost one-hot
            endcase
        end
    end

    // strobes line up with read_en / write_en
    assign load_ins  = (state == cpu_ctrl_pkg::ST_GET_INS) && done;
    assign load_rom  = (state == cpu_ctrl_pkg::ST_ROM_READ) && done;
    assign load_ram  = (state == cpu_ctrl_pkg::ST_RAM_READ) && done;
    assign ram_write = (state == cpu_ctrl_pkg::ST_RAM_WRITE) && done;
    assign exec      = (state == cpu_ctrl_pkg::ST_PROCESS);

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_ins,
    input  logic                load_rom,
    input  logic                load_ram,
    input  logic                exec,
    input  logic                ram_write,
    input  cpu_isa_pkg::byte_t  rd_data,
    input  cpu_isa_pkg::src_e   a_src,
    input  cpu_isa_pkg::src_e   b_src,
    input  cpu_isa_pkg::byte_t  alu_result,
    input  cpu_isa_pkg::byte_t  alu_flags,
    output cpu_isa_pkg::byte_t  opcode,
    output cpu_ctrl_pkg::addr_t pc,
    output cpu_isa_pkg::byte_t  direct_addr,
    output cpu_isa_pkg::byte_t  psw,
    output cpu_isa_pkg::byte_t  alu_a,
    output cpu_isa_pkg::byte_t  alu_b,
    output cpu_isa_pkg::byte_t  wr_data
);

    cpu_isa_pkg::byte_t acc;
    cpu_isa_pkg::byte_t b;
    cpu_isa_pkg::byte_t ram_data;
    cpu_isa_pkg::byte_t ram_rd;

    function automatic cpu_isa_pkg::byte_t pick(input cpu_isa_pkg::src_e src,
                                                input cpu_isa_pkg::byte_t acc_v,
                                                input cpu_isa_pkg::byte_t rom_v,
                                                input cpu_isa_pkg::byte_t ram_v);
        case (src)
            cpu_isa_pkg::SRC_ACC:      return acc_v;
            cpu_isa_pkg::SRC_ROM_DATA: return rom_v;
            cpu_isa_pkg::SRC_RAM_DATA: return ram_v;
            default:                   return '0;
        endcase
    endfunction

    assign alu_a   = pick(a_src, acc, direct_addr, ram_data);
    assign alu_b   = pick(b_src, acc, direct_addr, ram_data);
    assign wr_data = alu_a;

    // sfr addresses never reach the external bus data
    always_comb begin
        case (direct_addr)
            `CPU_SFR_ACC: ram_rd = acc;
            `CPU_SFR_B:   ram_rd = b;
            `CPU_SFR_PSW: ram_rd = psw;
            default:      ram_rd = rd_data;
        endcase
    end

    // rom operand byte doubles as the direct address
    always_ff @(posedge clk) begin
        if (load_ins)
            opcode <= rd_data;
        if (load_rom)
            direct_addr <= rd_data;
        if (load_ram)
            ram_data <= ram_rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            b   <= '0;
            psw <= '0;
            pc  <= '0;
        end else begin
            if (load_ins || load_rom)
                pc <= pc + cpu_ctrl_pkg::addr_t'(1);
            if (exec) begin
                acc <= alu_result;
                psw <= {alu_flags[7:1], ^alu_result};  // parity of new A
            end else if (ram_write) begin
                case (direct_addr)
                    `CPU_SFR_ACC: begin
                        acc    <= wr_data;
                        psw[0] <= ^wr_data;
                    end
                    `CPU_SFR_B:   b   <= wr_data;
                    `CPU_SFR_PSW: psw <= wr_data;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    output cpu_ctrl_pkg::addr_t  addr_bus,
    output logic                 read_en,
    output logic                 write_en,
    output logic                 memory_select,  // 0 rom, 1 ram
    output cpu_isa_pkg::byte_t   wr_data,
    input  cpu_isa_pkg::byte_t   rd_data
);

    cpu_ctrl_pkg::next_e  next_state;
    cpu_isa_pkg::phase_t  phase_init;
    cpu_isa_pkg::phase_t  phase;
    cpu_isa_pkg::alu_op_e alu_op;
    cpu_isa_pkg::src_e    a_src;
    cpu_isa_pkg::src_e    b_src;
    cpu_ctrl_pkg::addr_t  pc;
    cpu_isa_pkg::byte_t   direct_addr;
    cpu_isa_pkg::byte_t   opcode;
    cpu_isa_pkg::byte_t   psw;
    cpu_isa_pkg::byte_t   alu_a;
    cpu_isa_pkg::byte_t   alu_b;
    cpu_isa_pkg::byte_t   alu_result;
    cpu_isa_pkg::byte_t   alu_flags;
    logic                 load_ins;
    logic                 load_rom;
    logic                 load_ram;
    logic                 exec;
    logic                 ram_write;

    cpu_sequencer sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .next_state    (next_state),
        .phase_init    (phase_init),
        .pc            (pc),
        .direct_addr   (direct_addr),
        .addr_bus      (addr_bus),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select),
        .load_ins      (load_ins),
        .load_rom      (load_rom),
        .load_ram      (load_ram),
        .exec          (exec),
        .ram_write     (ram_write),
        .phase         (phase),
        .state         ()
    );

    ins_decoder decoder_i (
        .opcode     (opcode),
        .phase      (phase),
        .next_state (next_state),
        .phase_init (phase_init),
        .alu_op     (alu_op),
        .a_src      (a_src),
        .b_src      (b_src)
    );

    datapath datapath_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_ins    (load_ins),
        .load_rom    (load_rom),
        .load_ram    (load_ram),
        .exec        (exec),
        .ram_write   (ram_write),
        .rd_data     (rd_data),
        .a_src       (a_src),
        .b_src       (b_src),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .opcode      (opcode),
        .pc          (pc),
        .direct_addr (direct_addr),
        .psw         (psw),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .wr_data     (wr_data)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .psw_in (psw),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule

/* tests/cpu_props.sv */
`timescale 1ns/1ns

module cpu_props (
    input logic clk,
    input logic rst_n,
    input logic read_en,
    input logic write_en,
    input logic memory_select
);

    int fail_count = 0;

    strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_en && write_en))
    else begin
        fail_count++;
        $error("read_en and write_en high in the same cycle");
    end

    read_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        read_en |=> !read_en)
    else begin
        fail_count++;
        $error("read_en held for more than one cycle");
    end

    write_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |=> !write_en)
    else begin
        fail_count++;
        $error("write_en held for more than one cycle");
    end

    write_to_ram: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |-> memory_select)
    else begin
        fail_count++;
        $error("write_en high while ROM is selected");
    end

endmodule

bind cpu_top cpu_props props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_en       (read_en),
    .write_en      (write_en),
    .memory_select (memory_select)
);

/* tests/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker (
    input logic                clk,
    input logic                rst_n,
    input cpu_ctrl_pkg::addr_t addr_bus,
    input logic                read_en,
    input logic                write_en,
    input logic                memory_select,
    input logic                fetch,  // opcode read in this cycle
    input cpu_isa_pkg::byte_t  wr_data
);

    string               wr_name    [$];
    cpu_ctrl_pkg::addr_t wr_addr    [$];
    cpu_isa_pkg::byte_t  wr_exp     [$];
    string               fetch_name [$];
    cpu_ctrl_pkg::addr_t fetch_addr [$];
    int                  mismatches = 0;
    int                  failures   = 0;
    int                  fetch_seen = 0;
    logic                running    = 1'b0;
    string               name;
    cpu_ctrl_pkg::addr_t exp_addr;
    cpu_isa_pkg::byte_t  exp_data;

    task automatic expect_write(input string n, input cpu_ctrl_pkg::addr_t a,
                                input cpu_isa_pkg::byte_t d);
        wr_name.push_back(n);
        wr_addr.push_back(a);
        wr_exp.push_back(d);
    endtask

    task automatic expect_fetch(input string n, input cpu_ctrl_pkg::addr_t a);
        fetch_name.push_back(n);
        fetch_addr.push_back(a);
    endtask

    task automatic check_drained();
        if (wr_exp.size() != 0) begin
            $display("error: %0d expected writes never happened", wr_exp.size());
            failures++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && !running) begin
            running <= 1'b1;
            if (read_en || write_en || !memory_select || addr_bus != '0) begin
                $display("error: bus not idle right after reset");
                failures++;
            end
        end
        if (rst_n && read_en && fetch) begin
            if (memory_select) begin
                $display("error: instruction fetch with RAM selected");
                failures++;
            end
            if (fetch_addr.size() == 0) begin
                $display("error: fetch at %04h past the end of the program", addr_bus);
                failures++;
            end else begin
                name     = fetch_name.pop_front();
                exp_addr = fetch_addr.pop_front();
                if (addr_bus != exp_addr) begin
                    $display("mismatch %s fetch address: expected %04h, actual %04h",
                             name, exp_addr, addr_bus);
                    mismatches++;
                end
            end
            fetch_seen++;
        end
        if (rst_n && write_en) begin
            if (fetch_seen == 0) begin
                $display("error: write strobe before the first instruction fetch");
                failures++;
            end
            if (wr_exp.size() == 0) begin
                $display("error: unexpected write of %02h to %04h", wr_data, addr_bus);
                failures++;
            end else begin
                name     = wr_name.pop_front();
                exp_addr = wr_addr.pop_front();
                exp_data = wr_exp.pop_front();
                if (addr_bus != exp_addr) begin
                    $display("mismatch %s write address: expected %04h, actual %04h",
                             name, exp_addr, addr_bus);
                    mismatches++;
                end
                if (wr_data != exp_data) begin
                    $display("mismatch %s write data: expected %02h, actual %02h",
                             name, exp_data, wr_data);
                    mismatches++;
                end
            end
        end
    end

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module tb_cpu;

    localparam int ROWS         = 11;
    localparam int RESET_CYCLES = 8;

    logic                clk = 1'b0;
    logic                rst_n;
    cpu_ctrl_pkg::addr_t addr_bus;
    logic                read_en;
    logic                write_en;
    logic                memory_select;
    cpu_isa_pkg::byte_t  wr_data;
    cpu_isa_pkg::byte_t  rd_data;

    cpu_isa_pkg::byte_t  rom   [256];
    cpu_isa_pkg::byte_t  ram   [256];
    cpu_isa_pkg::byte_t  m_ram [256];  // model view of ram
    cpu_isa_pkg::byte_t  m_acc   = '0;
    cpu_isa_pkg::byte_t  m_psw   = '0;
    int                  pc_w    = 0;
    int                  n_instr = 0;
    int                  limit   = 0;
    int                  errors;

    // each row runs as MOV A,#a then op then MOV dir,A
    string               row_name [ROWS];
    cpu_isa_pkg::byte_t  row_op   [ROWS];
    cpu_isa_pkg::byte_t  row_a    [ROWS];
    cpu_isa_pkg::byte_t  row_b    [ROWS];  // immediate or direct address
    cpu_isa_pkg::byte_t  row_dir  [ROWS];
    cpu_isa_pkg::byte_t  row_exp  [ROWS];

    always #2 clk = ~clk;

    cpu_top cpu_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr_bus      (addr_bus),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select),
        .wr_data       (wr_data),
        .rd_data       (rd_data)
    );

    cpu_checker checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr_bus      (addr_bus),
        .read_en       (read_en),
        .write_en      (write_en),
        .memory_select (memory_select),
        .fetch         (cpu_top_i.load_ins),
        .wr_data       (wr_data)
    );

    assign rd_data = !read_en ? '0 : (memory_select ? ram[addr_bus[7:0]] : rom[addr_bus[7:0]]);

    always @(posedge clk) begin
        if (write_en && memory_select)
            ram[addr_bus[7:0]] <= wr_data;
    end

    task automatic set_row(input int i, input string name, input cpu_isa_pkg::byte_t op,
                           input cpu_isa_pkg::byte_t a, input cpu_isa_pkg::byte_t b,
                           input cpu_isa_pkg::byte_t dir);
        row_name[i] = name;
        row_op[i]   = op;
        row_a[i]    = a;
        row_b[i]    = b;
        row_dir[i]  = dir;
    endtask

    function automatic cpu_isa_pkg::byte_t read_dir(input cpu_isa_pkg::byte_t dir);
        if (dir == `CPU_SFR_ACC)
            return m_acc;
        if (dir == `CPU_SFR_PSW)
            return m_psw;
        return m_ram[dir];
    endfunction

    task automatic model_exec(input cpu_isa_pkg::byte_t op, input cpu_isa_pkg::byte_t arg);
        int                 sum;
        int                 ssum;
        cpu_isa_pkg::byte_t v;
        v = (op == 8'hE5 || op == 8'h25) ? read_dir(arg) : arg;
        case (op)
            8'h74, 8'hE5: m_acc = v;
            8'h24, 8'h25: begin
                sum      = int'(m_acc) + int'(v);
                ssum     = int'($signed(m_acc)) + int'($signed(v));
                m_psw[7] = sum > 255;
                m_psw[6] = (m_acc % 16) + (v % 16) > 15;
                m_psw[2] = ssum > 127 || ssum < -128;
                m_acc    = 8'(sum);
            end
            8'h54: m_acc = m_acc & v;
            8'h44: m_acc = m_acc | v;
            8'h64: m_acc = m_acc ^ v;
            8'hF5: m_ram[arg] = m_acc;
            default: ;
        endcase
        m_psw[0] = ^m_acc;  // parity always follows A
    endtask

    task automatic add_ins(input string name, input cpu_isa_pkg::byte_t op,
                           input cpu_isa_pkg::byte_t arg);
        checker_i.expect_fetch(name, cpu_ctrl_pkg::addr_t'(pc_w));
        rom[pc_w[7:0]] = op;
        pc_w++;
        if (op != 8'h00) begin
            rom[pc_w[7:0]] = arg;
            pc_w++;
        end
        model_exec(op, arg);
        n_instr++;
    endtask

    initial begin
        int i;
        rst_n <= 1'b0;
        void'($urandom(32'h5bfe));
        for (i = 0; i < 256; i++) begin
            rom[i[7:0]]   = 8'(i) ^ 8'h3c;
            ram[i[7:0]]   <= 8'(i) ^ 8'ha5;
            m_ram[i[7:0]] = 8'(i) ^ 8'ha5;
        end
        set_row(0,  "mov_imm",   8'h74, 8'h11, 8'h5a, 8'h30);
        set_row(1,  "add_imm",   8'h24, 8'h7f, 8'h01, 8'h31);
        set_row(2,  "psw_add",   8'hE5, 8'h00, `CPU_SFR_PSW, 8'h32);
        set_row(3,  "add_carry", 8'h24, 8'hc8, 8'h9c, 8'h33);
        set_row(4,  "psw_carry", 8'hE5, 8'h01, `CPU_SFR_PSW, 8'h34);
        set_row(5,  "anl_rand",  8'h54, 8'($urandom), 8'($urandom), 8'h35);
        set_row(6,  "orl_rand",  8'h44, 8'($urandom), 8'($urandom), 8'h36);
        set_row(7,  "xrl_rand",  8'h64, 8'($urandom), 8'($urandom), 8'h37);
        set_row(8,  "add_dir",   8'h25, 8'h23, 8'h30, 8'h38);  // reads mov_imm store
        set_row(9,  "acc_sfr",   8'hE5, 8'hc3, `CPU_SFR_ACC, 8'h39);
        set_row(10, "nop_mid",   8'h00, 8'h66, 8'h00, 8'h3a);
        for (i = 0; i < ROWS; i++) begin
            if (i % 2 == 1)
                add_ins(row_name[i], 8'h00, 8'h00);  // shifts the layout by one byte
            add_ins(row_name[i], 8'h74, row_a[i]);
            add_ins(row_name[i], row_op[i], row_b[i]);
            add_ins(row_name[i], 8'hF5, row_dir[i]);
            row_exp[i] = m_acc;
            checker_i.expect_write(row_name[i], cpu_ctrl_pkg::addr_t'(row_dir[i]), row_exp[i]);
        end
        checker_i.expect_fetch("end", cpu_ctrl_pkg::addr_t'(pc_w));
        rom[pc_w[7:0]] = 8'h00;
        limit = RESET_CYCLES + `CPU_NOP_DURATION + 1 + 12 * (n_instr + 1) + 40;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (checker_i.fetch_seen < n_instr + 1)
            @(posedge clk);
        repeat (2) @(posedge clk);
        checker_i.check_drained();
        errors = checker_i.mismatches + checker_i.failures + cpu_top_i.props_i.fail_count;
        $display("errors: %0d mismatches, %0d other checks, %0d assertions",
                 checker_i.mismatches, checker_i.failures, cpu_top_i.props_i.fail_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit != 0);
        repeat (limit) @(posedge clk);
        $display("error: watchdog expired after %0d cycles before the program ended", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/alu.sv
hdl/ins_decoder.sv
hdl/cpu_sequencer.sv
hdl/datapath.sv
hdl/cpu_top.sv
tests/cpu_props.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
